// ==== Bender.yml ====
package:
  name: dma_subsystem

sources:
  - hw/dma_cfg_pkg.sv
  - hw/dma_bus_pkg.sv
  - hw/dma_ctrl_unit.sv
  - hw/dma_cmd_queue.sv
  - hw/dma_transfer_engine.sv
  - hw/dma_subsystem.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_dma_subsystem.sv

// ==== dma_subsystem.f ====
hw/dma_cfg_pkg.sv
hw/dma_bus_pkg.sv
hw/dma_ctrl_unit.sv
hw/dma_cmd_queue.sv
hw/dma_transfer_engine.sv
hw/dma_subsystem.sv
test/tb_mem_model.sv
test/tb_dma_subsystem.sv

// ==== hw/dma_bus_pkg.sv ====
// ==============================
// DMA bus package
// Port structs, queued command and control word
// ==============================

package dma_bus_pkg;

  // Request side of a req/gnt/r_valid port
  typedef struct packed {
    logic                                req;
    logic [dma_cfg_pkg::ADDR_WIDTH-1:0]  add;
    logic                                wen;  // Low for write
    logic [dma_cfg_pkg::BE_WIDTH-1:0]    be;
    logic [dma_cfg_pkg::DATA_WIDTH-1:0]  wdata;
  } ctrl_req_t;

  // Response side, r_valid one cycle after a granted read
  typedef struct packed {
    logic                                gnt;
    logic                                r_valid;
    logic [dma_cfg_pkg::DATA_WIDTH-1:0]  r_rdata;
  } ctrl_rsp_t;

  // Memory ports share the control port layout
  typedef ctrl_req_t mem_req_t;
  typedef ctrl_rsp_t mem_rsp_t;

  // One pending transfer
  typedef struct packed {
    logic [dma_cfg_pkg::CORE_ID_WIDTH-1:0] core_id;
    logic [dma_cfg_pkg::ADDR_WIDTH-1:0]    tcdm_addr;
    logic [dma_cfg_pkg::ADDR_WIDTH-1:0]    ext_addr;
    logic [dma_cfg_pkg::LEN_WIDTH-1:0]     len;
    logic                                  to_ext;  // TCDM to external when set
  } dma_cmd_t;

  // Command register layout
  typedef struct packed {
    logic                                to_ext;
    logic [22:0]                         rsvd;
    logic [dma_cfg_pkg::LEN_WIDTH-1:0]   len;
  } cmd_word_t;

  // Write data seen as an address or as a command, picked by offset
  typedef union packed {
    logic [dma_cfg_pkg::ADDR_WIDTH-1:0] addr;
    cmd_word_t                          cmd;
  } dma_ctrl_word_u;

endpackage

// ==== hw/dma_cfg_pkg.sv ====
// ==============================
// DMA configuration package
// Sizes and register map of the subsystem
// ==============================

package dma_cfg_pkg;

  localparam int unsigned NB_CORES      = 2;  // Control ports and event bits
  localparam int unsigned CORE_ID_WIDTH = 1;

  localparam int unsigned ADDR_WIDTH = 32;  // Byte address
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = 4;   // Also bytes per word
  localparam int unsigned LEN_WIDTH  = 8;   // Transfer length in words

  // Command queue
  localparam int unsigned QUEUE_DEPTH     = 4;
  localparam int unsigned QUEUE_PTR_WIDTH = 2;
  localparam int unsigned QUEUE_CNT_WIDTH = 3;  // Holds 0 to QUEUE_DEPTH

  // Control port register offsets
  localparam logic [3:0] REG_TCDM_ADDR = 4'h0;
  localparam logic [3:0] REG_EXT_ADDR  = 4'h4;
  localparam logic [3:0] REG_CMD       = 4'h8;
  localparam logic [3:0] REG_STATUS    = 4'hC;

endpackage

// ==== hw/dma_cmd_queue.sv ====
// ==============================
// DMA command queue
// Circular FIFO of pending commands
// ==============================
`timescale 1ns/1ps

module dma_cmd_queue (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  push_i,
  input  dma_bus_pkg::dma_cmd_t cmd_i,
  input  logic                  pop_i,
  output dma_bus_pkg::dma_cmd_t cmd_o,
  output logic                  empty_o,
  output logic                  full_o
);

  dma_bus_pkg::dma_cmd_t                     mem_q [dma_cfg_pkg::QUEUE_DEPTH];
  logic [dma_cfg_pkg::QUEUE_PTR_WIDTH-1:0]   wr_ptr_q;
  logic [dma_cfg_pkg::QUEUE_PTR_WIDTH-1:0]   rd_ptr_q;
  logic [dma_cfg_pkg::QUEUE_CNT_WIDTH-1:0]   count_q;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == dma_cfg_pkg::QUEUE_CNT_WIDTH'(dma_cfg_pkg::QUEUE_DEPTH));
  assign cmd_o   = mem_q[rd_ptr_q];  // Head entry

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;  // Depth is a power of two
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= cmd_i;
  end

  // Producer and consumer must respect the flags
  a_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      push_i |-> !full_o)
    else $error("Push while queue is full");

  a_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pop_i |-> !empty_o)
    else $error("Pop while queue is empty");

endmodule

// ==== hw/dma_ctrl_unit.sv ====
// ==============================
// DMA control unit
// Per-core registers, round-robin command issue
// ==============================
`timescale 1ns/1ps

module dma_ctrl_unit (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  dma_bus_pkg::ctrl_req_t [dma_cfg_pkg::NB_CORES-1:0] ctrl_req_i,
  output dma_bus_pkg::ctrl_rsp_t [dma_cfg_pkg::NB_CORES-1:0] ctrl_rsp_o,
  input  logic                                               full_i,
  output logic                                               push_o,
  output dma_bus_pkg::dma_cmd_t                              cmd_o,
  input  logic [dma_cfg_pkg::NB_CORES-1:0]                   done_i
);

  logic [dma_cfg_pkg::NB_CORES-1:0][dma_cfg_pkg::ADDR_WIDTH-1:0] tcdm_addr_q;
  logic [dma_cfg_pkg::NB_CORES-1:0][dma_cfg_pkg::ADDR_WIDTH-1:0] ext_addr_q;
  logic [dma_cfg_pkg::NB_CORES-1:0][dma_cfg_pkg::DATA_WIDTH-1:0] done_cnt_q;
  logic [dma_cfg_pkg::NB_CORES-1:0][dma_cfg_pkg::DATA_WIDTH-1:0] rd_word;
  logic [dma_cfg_pkg::NB_CORES-1:0][dma_cfg_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [dma_cfg_pkg::NB_CORES-1:0]                              r_valid_q;
  logic [dma_cfg_pkg::NB_CORES-1:0]                              rd_hit;
  logic [dma_cfg_pkg::NB_CORES-1:0]                              wr_hit;
  logic [dma_cfg_pkg::NB_CORES-1:0]                              cmd_req;
  logic [dma_cfg_pkg::NB_CORES-1:0][3:0]                         offset;
  dma_bus_pkg::dma_ctrl_word_u [dma_cfg_pkg::NB_CORES-1:0]       wword;
  logic [dma_cfg_pkg::CORE_ID_WIDTH-1:0]                         rr_ptr_q;
  logic [dma_cfg_pkg::CORE_ID_WIDTH-1:0]                         winner;
  logic                                                          grant_valid;

  // First pending REG_CMD write at or after the pointer
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    winner      = '0;
    for (int k = 0; k < dma_cfg_pkg::NB_CORES; k++) begin
      idx = (int'(rr_ptr_q) + k) % dma_cfg_pkg::NB_CORES;
      if (!grant_valid && cmd_req[idx]) begin
        grant_valid = 1'b1;
        winner      = dma_cfg_pkg::CORE_ID_WIDTH'(idx);
      end
    end
  end

  assign push_o = grant_valid & ~full_i;

  always_comb begin
    cmd_o.core_id   = winner;
    cmd_o.tcdm_addr = tcdm_addr_q[winner];
    cmd_o.ext_addr  = ext_addr_q[winner];
    cmd_o.len       = wword[winner].cmd.len;     // Command view of wdata
    cmd_o.to_ext    = wword[winner].cmd.to_ext;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
    end else if (push_o) begin
      // Winner drops to lowest priority
      if (winner == dma_cfg_pkg::CORE_ID_WIDTH'(dma_cfg_pkg::NB_CORES - 1)) rr_ptr_q <= '0;
      else rr_ptr_q <= winner + 1'b1;
    end
  end

  for (genvar i = 0; i < dma_cfg_pkg::NB_CORES; i++) begin : gen_port
    assign offset[i]  = ctrl_req_i[i].add[3:0];
    assign wword[i]   = ctrl_req_i[i].wdata;
    assign rd_hit[i]  = ctrl_req_i[i].req & ctrl_req_i[i].wen;
    assign wr_hit[i]  = ctrl_req_i[i].req & ~ctrl_req_i[i].wen;
    assign cmd_req[i] = wr_hit[i] & (offset[i] == dma_cfg_pkg::REG_CMD);

    // Everything but a command write is granted at once
    assign ctrl_rsp_o[i].gnt = cmd_req[i] ?
        (push_o & (winner == dma_cfg_pkg::CORE_ID_WIDTH'(i))) : ctrl_req_i[i].req;
    assign ctrl_rsp_o[i].r_valid = r_valid_q[i];
    assign ctrl_rsp_o[i].r_rdata = rdata_q[i];

    always_comb begin
      case (offset[i])
        dma_cfg_pkg::REG_TCDM_ADDR: rd_word[i] = tcdm_addr_q[i];
        dma_cfg_pkg::REG_EXT_ADDR:  rd_word[i] = ext_addr_q[i];
        dma_cfg_pkg::REG_STATUS:    rd_word[i] = done_cnt_q[i];  // Completed commands
        default:                    rd_word[i] = '0;
      endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        r_valid_q[i]  <= 1'b0;
        done_cnt_q[i] <= '0;
      end else begin
        r_valid_q[i] <= rd_hit[i];
        if (done_i[i]) done_cnt_q[i] <= done_cnt_q[i] + 1'b1;  // Wraps
      end
    end

    // Word-aligned address registers and read data
    always_ff @(posedge clk_i) begin
      if (wr_hit[i] && offset[i] == dma_cfg_pkg::REG_TCDM_ADDR)
        tcdm_addr_q[i] <= {wword[i].addr[dma_cfg_pkg::ADDR_WIDTH-1:2], 2'b00};
      if (wr_hit[i] && offset[i] == dma_cfg_pkg::REG_EXT_ADDR)
        ext_addr_q[i] <= {wword[i].addr[dma_cfg_pkg::ADDR_WIDTH-1:2], 2'b00};
      if (rd_hit[i]) rdata_q[i] <= rd_word[i];
    end

    // A waiting command write stays on the port until its gnt
    a_cmd_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (cmd_req[i] && !ctrl_rsp_o[i].gnt) |=> cmd_req[i])
      else $error("REG_CMD write dropped before its gnt");
  end

endmodule

// ==== hw/dma_subsystem.sv ====
// ==============================
// DMA subsystem top
// Control unit, command queue, engine
// ==============================
`timescale 1ns/1ps

module dma_subsystem (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  dma_bus_pkg::ctrl_req_t [dma_cfg_pkg::NB_CORES-1:0] ctrl_req_i,
  output dma_bus_pkg::ctrl_rsp_t [dma_cfg_pkg::NB_CORES-1:0] ctrl_rsp_o,
  output dma_bus_pkg::mem_req_t                              tcdm_req_o,
  input  dma_bus_pkg::mem_rsp_t                              tcdm_rsp_i,
  output dma_bus_pkg::mem_req_t                              ext_req_o,
  input  dma_bus_pkg::mem_rsp_t                              ext_rsp_i,
  output logic [dma_cfg_pkg::NB_CORES-1:0]                   term_event_o,
  output logic                                               busy_o
);

  logic                  push, pop, full, empty, active;
  dma_bus_pkg::dma_cmd_t push_cmd;
  dma_bus_pkg::dma_cmd_t head_cmd;

  dma_ctrl_unit ctrl_unit_i (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .ctrl_req_i ( ctrl_req_i   ),
    .ctrl_rsp_o ( ctrl_rsp_o   ),
    .full_i     ( full         ),
    .push_o     ( push         ),
    .cmd_o      ( push_cmd     ),
    .done_i     ( term_event_o )   // Completion counters
  );

  dma_cmd_queue cmd_queue_i (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .push_i   ( push     ),
    .cmd_i    ( push_cmd ),
    .pop_i    ( pop      ),
    .cmd_o    ( head_cmd ),
    .empty_o  ( empty    ),
    .full_o   ( full     )
  );

  dma_transfer_engine transfer_engine_i (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .empty_i    ( empty        ),
    .cmd_i      ( head_cmd     ),
    .pop_o      ( pop          ),
    .tcdm_req_o ( tcdm_req_o   ),
    .tcdm_rsp_i ( tcdm_rsp_i   ),
    .ext_req_o  ( ext_req_o    ),
    .ext_rsp_i  ( ext_rsp_i    ),
    .done_o     ( term_event_o ),
    .active_o   ( active       )
  );

  assign busy_o = ~empty | active;  // Queued or in flight

endmodule

// ==== hw/dma_transfer_engine.sv ====
// ==============================
// DMA transfer engine
// Word copy between TCDM and external port
// ==============================
`timescale 1ns/1ps

module dma_transfer_engine (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             empty_i,
  input  dma_bus_pkg::dma_cmd_t            cmd_i,
  output logic                             pop_o,
  output dma_bus_pkg::mem_req_t            tcdm_req_o,
  input  dma_bus_pkg::mem_rsp_t            tcdm_rsp_i,
  output dma_bus_pkg::mem_req_t            ext_req_o,
  input  dma_bus_pkg::mem_rsp_t            ext_rsp_i,
  output logic [dma_cfg_pkg::NB_CORES-1:0] done_o,
  output logic                             active_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,   // Source read until gnt
    ST_WAIT,   // Waiting for read data
    ST_WRITE,  // Destination write until gnt
    ST_DONE
  } state_e;

  state_e                                 state_q, state_d;
  dma_bus_pkg::dma_cmd_t                  cmd_q;  // Running addresses and remaining length
  logic [dma_cfg_pkg::DATA_WIDTH-1:0]     data_q;
  dma_bus_pkg::mem_req_t                  rd_req;
  dma_bus_pkg::mem_req_t                  wr_req;
  dma_bus_pkg::mem_rsp_t                  src_rsp;
  dma_bus_pkg::mem_rsp_t                  dst_rsp;
  logic                                   last_word;

  assign pop_o     = (state_q == ST_IDLE) && !empty_i;
  assign active_o  = (state_q != ST_IDLE);
  assign last_word = (cmd_q.len == dma_cfg_pkg::LEN_WIDTH'(1));

  // Port steering by direction
  assign src_rsp = cmd_q.to_ext ? tcdm_rsp_i : ext_rsp_i;
  assign dst_rsp = cmd_q.to_ext ? ext_rsp_i : tcdm_rsp_i;

  always_comb begin
    rd_req       = '0;
    rd_req.req   = (state_q == ST_READ);
    rd_req.add   = cmd_q.to_ext ? cmd_q.tcdm_addr : cmd_q.ext_addr;
    rd_req.wen   = 1'b1;
    rd_req.be    = '1;

    wr_req       = '0;
    wr_req.req   = (state_q == ST_WRITE);
    wr_req.add   = cmd_q.to_ext ? cmd_q.ext_addr : cmd_q.tcdm_addr;
    wr_req.wen   = 1'b0;
    wr_req.be    = '1;  // Full word
    wr_req.wdata = data_q;

    tcdm_req_o = cmd_q.to_ext ? rd_req : wr_req;
    ext_req_o  = cmd_q.to_ext ? wr_req : rd_req;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!empty_i) state_d = (cmd_i.len == '0) ? ST_DONE : ST_READ;
      end
      ST_READ:  if (src_rsp.gnt) state_d = ST_WAIT;
      ST_WAIT:  if (src_rsp.r_valid) state_d = ST_WRITE;
      ST_WRITE: begin
        if (dst_rsp.gnt) state_d = last_word ? ST_DONE : ST_READ;
      end
      ST_DONE:  state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  // One-cycle event to the issuing core
  always_comb begin
    done_o = '0;
    if (state_q == ST_DONE) done_o[cmd_q.core_id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cmd_q   <= '0;
    end else begin
      state_q <= state_d;
      if (pop_o) begin
        cmd_q <= cmd_i;
      end else if (state_q == ST_WRITE && dst_rsp.gnt) begin
        cmd_q.tcdm_addr <= cmd_q.tcdm_addr + dma_cfg_pkg::ADDR_WIDTH'(dma_cfg_pkg::BE_WIDTH);
        cmd_q.ext_addr  <= cmd_q.ext_addr + dma_cfg_pkg::ADDR_WIDTH'(dma_cfg_pkg::BE_WIDTH);
        cmd_q.len       <= cmd_q.len - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_WAIT && src_rsp.r_valid) data_q <= src_rsp.r_rdata;
  end

  // Memories return data only for the single read in flight
  a_rvalid_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (tcdm_rsp_i.r_valid || ext_rsp_i.r_valid) |-> (state_q == ST_WAIT))
    else $error("Read data outside the wait-data state");

endmodule

// ==== test/tb_dma_subsystem.sv ====
// ==============================
// DMA subsystem testbench
// Directed copies checked through memory models
// ==============================
`timescale 1ns/1ps

module tb_dma_subsystem;

  localparam int unsigned MAX_CYCLES = 20000;  // Far above six stalled 8-word copies
  localparam int unsigned NB_CORES   = dma_cfg_pkg::NB_CORES;

  logic                                    clk;
  logic                                    arst_n;
  dma_bus_pkg::ctrl_req_t [NB_CORES-1:0]   ctrl_req;
  dma_bus_pkg::ctrl_rsp_t [NB_CORES-1:0]   ctrl_rsp;
  dma_bus_pkg::mem_req_t                   tcdm_req;
  dma_bus_pkg::mem_rsp_t                   tcdm_rsp;
  dma_bus_pkg::mem_req_t                   ext_req;
  dma_bus_pkg::mem_rsp_t                   ext_rsp;
  logic [NB_CORES-1:0]                     term_event;
  logic                                    busy;

  int          errors;
  int          cycles;
  int          ev_cnt [NB_CORES];     // Event pulses seen per core
  int          exp_done [NB_CORES];   // Commands issued per core
  int          cmd_granted;
  int          cmd_withheld;
  int          total_events;
  logic [NB_CORES-1:0] ev_seen;

  dma_subsystem UUT (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .ctrl_req_i   ( ctrl_req   ),
    .ctrl_rsp_o   ( ctrl_rsp   ),
    .tcdm_req_o   ( tcdm_req   ),
    .tcdm_rsp_i   ( tcdm_rsp   ),
    .ext_req_o    ( ext_req    ),
    .ext_rsp_i    ( ext_rsp    ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  tb_mem_model #(.FILL_SALT(32'h0bad_cafe)) tcdm_mem (
    .clk_i(clk), .arst_n_i(arst_n), .req_i(tcdm_req), .rsp_o(tcdm_rsp));
  tb_mem_model #(.FILL_SALT(32'h5eed_f00d)) ext_mem (
    .clk_i(clk), .arst_n_i(arst_n), .req_i(ext_req), .rsp_o(ext_rsp));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DMA did not finish its commands", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Event and REG_CMD handshake monitor at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (term_event[c]) begin
          ev_cnt[c]++;
          total_events++;
        end
        if (ctrl_req[c].req && !ctrl_req[c].wen &&
            ctrl_req[c].add[3:0] == dma_cfg_pkg::REG_CMD) begin
          if (ctrl_rsp[c].gnt) cmd_granted++;
          else cmd_withheld++;
        end
      end
      ev_seen = ev_seen | term_event;
      // Queue entries plus the one in the engine
      if (cmd_granted - total_events > int'(dma_cfg_pkg::QUEUE_DEPTH) + 1)
        report_failure("REG_CMD granted although the command queue was full");
    end
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("%0t: Failure, %s", $time, msg);
  endtask

  task automatic check_word(input string name, input logic [dma_cfg_pkg::DATA_WIDTH-1:0] exp,
                            input logic [dma_cfg_pkg::DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_events(input string name, input logic [NB_CORES-1:0] exp,
                              input logic [NB_CORES-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error [%s] expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic dma_bus_pkg::ctrl_req_t make_req(input logic [3:0] offset,
                                                      input logic wen,
                                                      input logic [31:0] wdata);
    dma_bus_pkg::ctrl_req_t r;
    r.req   = 1'b1;
    r.add   = {28'h0, offset};
    r.wen   = wen;
    r.be    = '1;
    r.wdata = wdata;
    return r;
  endfunction

  // Source word of a copy tagged per test
  function automatic logic [31:0] src_word(input logic [7:0] tag, input int idx);
    return {tag, 8'hc3, 16'(idx) ^ 16'h5a00};
  endfunction

  task automatic ctrl_write(input int core, input logic [3:0] offset, input logic [31:0] wdata);
    @(posedge clk);
    ctrl_req[core] <= make_req(offset, 1'b0, wdata);
    do @(negedge clk); while (!ctrl_rsp[core].gnt);
  endtask

  task automatic ctrl_release(input int core);
    @(posedge clk);
    ctrl_req[core] <= '0;
  endtask

  task automatic issue_copy(input int core, input logic [31:0] tcdm_addr,
                            input logic [31:0] ext_addr, input logic [7:0] len,
                            input logic to_ext);
    ctrl_write(core, dma_cfg_pkg::REG_TCDM_ADDR, tcdm_addr);
    ctrl_write(core, dma_cfg_pkg::REG_EXT_ADDR, ext_addr);
    ctrl_write(core, dma_cfg_pkg::REG_CMD, {to_ext, 23'd0, len});
    exp_done[core]++;
  endtask

  // Status read with r_valid expected one cycle after gnt
  task automatic expect_status(input string name, input int core);
    logic [31:0] value;
    @(posedge clk);
    ctrl_req[core] <= make_req(dma_cfg_pkg::REG_STATUS, 1'b1, '0);
    do @(negedge clk); while (!ctrl_rsp[core].gnt);
    if (ctrl_rsp[core].r_valid)
      report_failure($sformatf("%s, r_valid already high in the status gnt cycle", name));
    @(posedge clk);
    ctrl_req[core] <= '0;
    @(negedge clk);
    if (!ctrl_rsp[core].r_valid)
      report_failure($sformatf("%s, no r_valid one cycle after the status gnt", name));
    value = ctrl_rsp[core].r_rdata;
    check_word(name, 32'(exp_done[core]), value);
  endtask

  task automatic poke_word(input logic ext, input logic [31:0] addr, input logic [31:0] data);
    if (ext) ext_mem.poke(addr, data);
    else tcdm_mem.poke(addr, data);
  endtask

  task automatic peek_word(input logic ext, input logic [31:0] addr, output logic [31:0] data);
    if (ext) ext_mem.peek(addr, data);
    else tcdm_mem.peek(addr, data);
  endtask

  task automatic load_source(input logic ext, input logic [31:0] base, input int len,
                             input logic [7:0] tag);
    for (int i = 0; i < len; i++) poke_word(ext, base + 32'(4 * i), src_word(tag, i));
  endtask

  task automatic compare_copy(input string name, input logic ext, input logic [31:0] base,
                              input int len, input logic [7:0] tag);
    logic [31:0] w;
    for (int i = 0; i < len; i++) begin
      peek_word(ext, base + 32'(4 * i), w);
      check_word($sformatf("%s word %0d", name, i), src_word(tag, i), w);
    end
  endtask

  // Every issued command gives exactly one event
  task automatic compare_counts(input string name);
    for (int c = 0; c < NB_CORES; c++)
      check_word($sformatf("%s events core %0d", name, c), 32'(exp_done[c]), 32'(ev_cnt[c]));
  endtask

  task automatic await_completion();
    for (int c = 0; c < NB_CORES; c++)
      while (ev_cnt[c] < exp_done[c]) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic reset_state();
    @(negedge clk);
    check_events("reset term events", '0, term_event);
    if (busy !== 1'b0) report_failure("busy_o is not low after reset");
    for (int c = 0; c < NB_CORES; c++) expect_status($sformatf("reset status %0d", c), c);
  endtask

  task automatic ext_to_tcdm();
    load_source(1'b1, 32'h100, 16, 8'h21);
    issue_copy(0, 32'h200, 32'h100, 8'd16, 1'b0);
    ctrl_release(0);
    await_completion();
    compare_copy("ext to tcdm", 1'b0, 32'h200, 16, 8'h21);
    compare_counts("ext to tcdm");
    expect_status("ext to tcdm status", 0);
  endtask

  task automatic tcdm_to_ext();
    logic [31:0] lo_before, hi_before, lo_after, hi_after;
    load_source(1'b0, 32'h404, 9, 8'h32);
    peek_word(1'b1, 32'h608, lo_before);  // Neighbours of the destination range
    peek_word(1'b1, 32'h630, hi_before);
    issue_copy(1, 32'h404, 32'h60c, 8'd9, 1'b1);
    ctrl_release(1);
    await_completion();
    compare_copy("tcdm to ext", 1'b1, 32'h60c, 9, 8'h32);
    peek_word(1'b1, 32'h608, lo_after);
    peek_word(1'b1, 32'h630, hi_after);
    check_word("tcdm to ext below range", lo_before, lo_after);
    check_word("tcdm to ext above range", hi_before, hi_after);
    compare_counts("tcdm to ext");
  endtask

  task automatic dual_core_issue();
    load_source(1'b1, 32'h800, 5, 8'h41);
    load_source(1'b0, 32'h900, 7, 8'h42);
    ev_seen = '0;
    fork
      begin
        issue_copy(0, 32'h800, 32'h800, 8'd5, 1'b0);
        ctrl_release(0);
      end
      begin
        issue_copy(1, 32'h900, 32'h900, 8'd7, 1'b1);
        ctrl_release(1);
      end
    join
    await_completion();
    check_events("dual core events", '1, ev_seen);
    compare_counts("dual core");
    compare_copy("dual core 0", 1'b0, 32'h800, 5, 8'h41);
    compare_copy("dual core 1", 1'b1, 32'h900, 7, 8'h42);
    expect_status("dual core status 0", 0);
    expect_status("dual core status 1", 1);
  endtask

  task automatic queue_backpressure();
    int withheld_start;
    withheld_start = cmd_withheld;
    for (int k = 0; k < 6; k++) load_source(1'b1, 32'ha00 + 32'(k * 'h40), 8, 8'(8'h50 + k));
    for (int k = 0; k < 6; k++)
      issue_copy(0, 32'hc00 + 32'(k * 'h40), 32'ha00 + 32'(k * 'h40), 8'd8, 1'b0);
    ctrl_release(0);
    await_completion();
    if (cmd_withheld == withheld_start)
      report_failure("REG_CMD gnt was never withheld while six commands were queued");
    for (int k = 0; k < 6; k++)
      compare_copy($sformatf("backpressure %0d", k), 1'b0, 32'hc00 + 32'(k * 'h40), 8,
                   8'(8'h50 + k));
    compare_counts("backpressure");
    @(negedge clk);
    if (busy !== 1'b0) report_failure("busy_o is not low after the queue drained");
  endtask

  task automatic zero_length();
    int tcdm_writes, ext_writes;
    tcdm_writes = tcdm_mem.wr_count;
    ext_writes  = ext_mem.wr_count;
    issue_copy(1, 32'h200, 32'h100, 8'd0, 1'b0);
    ctrl_release(1);
    await_completion();
    check_word("zero length tcdm writes", 32'(tcdm_writes), 32'(tcdm_mem.wr_count));
    check_word("zero length ext writes", 32'(ext_writes), 32'(ext_mem.wr_count));
    compare_counts("zero length");
    expect_status("zero length status", 1);
  endtask

  initial begin
    arst_n       = 1'b0;
    ctrl_req     = '0;
    errors       = 0;
    cycles       = 0;
    cmd_granted  = 0;
    cmd_withheld = 0;
    total_events = 0;
    ev_seen      = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      ev_cnt[c]   = 0;
      exp_done[c] = 0;
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    reset_state();
    ext_to_tcdm();
    tcdm_to_ext();
    dual_core_issue();
    queue_backpressure();
    zero_length();

    $display("Tests done in %0d cycles, %0d errors", cycles, errors);
    if (errors == 0) $display("Simulation PASSED");
    else $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== test/tb_mem_model.sv ====
// ==============================
// Testbench word memory
// req/gnt/r_valid port with random grant stalls
// ==============================
`timescale 1ns/1ps

module tb_mem_model #(
  parameter logic [31:0] FILL_SALT = 32'h0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  dma_bus_pkg::mem_req_t req_i,
  output dma_bus_pkg::mem_rsp_t rsp_o
);

  localparam int unsigned WORDS = 1024;  // 4 KB, word index is add[11:2]

  logic [dma_cfg_pkg::DATA_WIDTH-1:0] mem [WORDS];
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [31:0]                        rnd_q;
  logic                               stall_q;
  logic                               r_valid_q;
  logic [9:0]                         idx;
  int unsigned                        wr_count;  // Granted writes since start

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Initial contents, a function of the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ FILL_SALT;
  endfunction

  initial begin
    wr_count = 0;
    for (int i = 0; i < WORDS; i++) mem[i] = fill_word(32'(i) << 2);
  end

  assign idx           = req_i.add[11:2];
  assign rsp_o.gnt     = req_i.req & ~stall_q;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = rdata_q;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rnd_q     <= 32'h80fa_3fbe;
      stall_q   <= 1'b0;
      r_valid_q <= 1'b0;
      rdata_q   <= '0;
    end else begin
      rnd_q     <= xorshift(rnd_q);
      stall_q   <= (rnd_q[1:0] == 2'b00);  // About one stall in four
      r_valid_q <= rsp_o.gnt & req_i.wen;
      if (rsp_o.gnt && req_i.wen) rdata_q <= mem[idx];
      if (rsp_o.gnt && !req_i.wen) begin
        mem[idx] <= req_i.wdata;  // Full-word writes only
        wr_count <= wr_count + 1;
      end
    end
  end

  task automatic poke(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[11:2]] = data;
  endtask

  task automatic peek(input logic [31:0] addr, output logic [31:0] data);
    data = mem[addr[11:2]];
  endtask

endmodule
